// File: logic/arena_params.svh
`ifndef ARENA_PARAMS_SVH
`define ARENA_PARAMS_SVH

// Map size in tiles
`define ARENA_ROWS 11
`define ARENA_COLS 19

// Tile edge in pixels
`define TILE_PX 8

// Horizontal timing in pixel clocks
`define H_ACTIVE 152
`define H_FRONT 8
`define H_SYNC 16
`define H_TOTAL 200

// Vertical timing in lines
`define V_ACTIVE 88
`define V_FRONT 2
`define V_SYNC 3
`define V_TOTAL 100

// Countdown start, in frames
`define BOMB_FRAMES 9

// Beam coordinate to colour latency
`define PIPE_DELAY 2

// Player start tile
`define START_ROW 1
`define START_COL 1

`endif

// File: logic/arena_pkg.sv
`include "arena_params.svh"

package arena_pkg;

  typedef enum logic [1:0] {
    TILE_FLOOR = 2'd0,
    TILE_WALL  = 2'd1,
    TILE_BRICK = 2'd2,
    TILE_BOMB  = 2'd3
  } tile_t;

  typedef enum logic [2:0] {
    DIR_NONE  = 3'd0,
    DIR_UP    = 3'd1,
    DIR_DOWN  = 3'd2,
    DIR_LEFT  = 3'd3,
    DIR_RIGHT = 3'd4
  } dir_t;

  // Row times columns plus column
  typedef logic [7:0] map_addr_t;

  typedef struct packed {
    logic [3:0] row;
    logic [4:0] col;
  } tile_pos_t;

  function automatic map_addr_t pos_to_addr(tile_pos_t p);
    return map_addr_t'(int'(p.row) * `ARENA_COLS + int'(p.col));
  endfunction

  // One tile step, may wrap past the edge
  function automatic tile_pos_t step_pos(tile_pos_t p, dir_t d);
    tile_pos_t q;
    q = p;
    case (d)
      DIR_UP:    q.row = p.row - 4'd1;
      DIR_DOWN:  q.row = p.row + 4'd1;
      DIR_LEFT:  q.col = p.col - 5'd1;
      DIR_RIGHT: q.col = p.col + 5'd1;
      default:   q = p;
    endcase
    return q;
  endfunction

  // Wrapped steps land out of range here
  function automatic logic in_map(tile_pos_t p);
    return (int'(p.row) < `ARENA_ROWS) && (int'(p.col) < `ARENA_COLS);
  endfunction

  // Power-on layout of the arena
  function automatic tile_t reset_tile(int row, int col);
    tile_t t;
    if (row == 0 || col == 0 || row == `ARENA_ROWS - 1 || col == `ARENA_COLS - 1 ||
        (row % 2 == 0 && col % 2 == 0)) begin
      t = TILE_WALL;
    end else if ((row + col) % 3 == 0 && row + col > 3) begin
      // Corner near the start stays open
      t = TILE_BRICK;
    end else begin
      t = TILE_FLOOR;
    end
    return t;
  endfunction

endpackage

// File: logic/video_pkg.sv
package video_pkg;

  // Beam coordinates, 200 by 100 total
  typedef logic [7:0] scr_x_t;
  typedef logic [6:0] scr_y_t;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // Palette
  localparam rgb_t RGB_WALL   = '{r: 4'h8, g: 4'h8, b: 4'h8};
  localparam rgb_t RGB_BRICK  = '{r: 4'h9, g: 4'h5, b: 4'h1};
  localparam rgb_t RGB_BOMB   = '{r: 4'hf, g: 4'h0, b: 4'h0};
  localparam rgb_t RGB_FLOOR  = '{r: 4'h0, g: 4'h9, b: 4'h0};
  localparam rgb_t RGB_PLAYER = '{r: 4'hf, g: 4'hf, b: 4'hf};
  localparam rgb_t RGB_BLANK  = '{r: 4'h0, g: 4'h0, b: 4'h0};

endpackage

// File: logic/map_read_if.sv
`timescale 1ns/1ps

interface map_read_if;

  // Held by the requester until gnt
  logic                 req;
  arena_pkg::map_addr_t addr;

  // One-cycle grant, tile valid with it
  logic                 gnt;
  arena_pkg::tile_t     tile;

  modport requester (
    output req,
    output addr,
    input  gnt,
    input  tile
  );

  modport arbiter (
    input  req,
    input  addr,
    output gnt,
    output tile
  );

endinterface

// File: logic/tile_map.sv
`timescale 1ns/1ps

`include "arena_params.svh"

module tile_map (
  input  logic                 i_pixclk,
  input  logic                 i_arst_n,
  input  arena_pkg::map_addr_t i_rd_addr,
  input  arena_pkg::map_addr_t i_draw_addr,
  input  logic                 i_we,
  input  arena_pkg::map_addr_t i_wr_addr,
  input  arena_pkg::tile_t     i_wr_tile,
  output arena_pkg::tile_t     o_rd_tile,
  output arena_pkg::tile_t     o_draw_tile
);

  localparam int CELLS = `ARENA_ROWS * `ARENA_COLS;

  arena_pkg::tile_t mem [0:CELLS-1];

  // Reset reloads the start layout
  always_ff @(posedge i_pixclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int r = 0; r < `ARENA_ROWS; r++) begin
        for (int c = 0; c < `ARENA_COLS; c++) begin
          mem[r * `ARENA_COLS + c] <= arena_pkg::reset_tile(r, c);
        end
      end
    end else if (i_we) begin
      mem[i_wr_addr] <= i_wr_tile;
    end
  end

  // Arbitrated port, same-cycle read
  // Addresses past the map read as wall
  assign o_rd_tile = (int'(i_rd_addr) < CELLS) ? mem[i_rd_addr] : arena_pkg::TILE_WALL;

  // Renderer port, one cycle latency
  always_ff @(posedge i_pixclk) begin
    o_draw_tile <= (int'(i_draw_addr) < CELLS) ? mem[i_draw_addr] : arena_pkg::TILE_WALL;
  end

endmodule

// File: logic/map_read_arbiter.sv
`timescale 1ns/1ps

module map_read_arbiter (
  input  logic                 i_pixclk,
  input  logic                 i_arst_n,
  map_read_if.arbiter          bomb_rd,
  map_read_if.arbiter          plyr_rd,
  output arena_pkg::map_addr_t o_rd_addr,
  input  arena_pkg::tile_t     i_rd_tile
);

  logic gnt_bomb_q;
  logic gnt_plyr_q;
  logic busy;

  // No new grant while one is out, requester drops req after it
  assign busy = gnt_bomb_q | gnt_plyr_q;

  // Bomb logic wins over the player
  always_ff @(posedge i_pixclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      gnt_bomb_q <= 1'b0;
      gnt_plyr_q <= 1'b0;
    end else begin
      gnt_bomb_q <= !busy && bomb_rd.req;
      gnt_plyr_q <= !busy && !bomb_rd.req && plyr_rd.req;
    end
  end

  assign bomb_rd.gnt = gnt_bomb_q;
  assign plyr_rd.gnt = gnt_plyr_q;

  // Steer the granted address to the map
  assign o_rd_addr = gnt_bomb_q ? bomb_rd.addr : plyr_rd.addr;

  // Requester without grant sees a wall
  assign bomb_rd.tile = gnt_bomb_q ? i_rd_tile : arena_pkg::TILE_WALL;
  assign plyr_rd.tile = gnt_plyr_q ? i_rd_tile : arena_pkg::TILE_WALL;

endmodule

// File: logic/player_ctrl.sv
`timescale 1ns/1ps

`include "arena_params.svh"

module player_ctrl (
  input  logic                 i_pixclk,
  input  logic                 i_arst_n,
  input  logic                 i_tick,
  input  arena_pkg::dir_t      i_dir,
  map_read_if.requester        rd,
  output arena_pkg::tile_pos_t o_pos
);

  localparam arena_pkg::tile_pos_t START_POS = '{
    row: 4'(`START_ROW),
    col: 5'(`START_COL)
  };

  arena_pkg::tile_pos_t pos_q;
  arena_pkg::tile_pos_t tgt_q;
  arena_pkg::tile_pos_t nb_pos;
  logic                 req_q;
  logic                 start_move;

  // Tile one step away in the held direction
  assign nb_pos = arena_pkg::step_pos(pos_q, i_dir);

  // At most one attempt per frame
  assign start_move = i_tick && !req_q && (i_dir != arena_pkg::DIR_NONE) &&
                      arena_pkg::in_map(nb_pos);

  always_ff @(posedge i_pixclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      req_q <= 1'b0;
      pos_q <= START_POS;
    end else if (req_q) begin
      // Waits here while the bomb logic owns the port
      if (rd.gnt) begin
        req_q <= 1'b0;
        // Step only onto floor
        if (rd.tile == arena_pkg::TILE_FLOOR) begin
          pos_q <= tgt_q;
        end
      end
    end else if (start_move) begin
      req_q <= 1'b1;
    end
  end

  // Target held stable with the request
  always_ff @(posedge i_pixclk) begin
    if (start_move) begin
      tgt_q <= nb_pos;
    end
  end

  assign rd.req  = req_q;
  assign rd.addr = arena_pkg::pos_to_addr(tgt_q);
  assign o_pos   = pos_q;

endmodule

// File: logic/bomb_ctrl.sv
`timescale 1ns/1ps

`include "arena_params.svh"

module bomb_ctrl (
  input  logic                 i_pixclk,
  input  logic                 i_arst_n,
  input  logic                 i_tick,
  input  logic                 i_place,
  input  arena_pkg::tile_pos_t i_pos,
  map_read_if.requester        rd,
  output logic                 o_we,
  output arena_pkg::map_addr_t o_wr_addr,
  output arena_pkg::tile_t     o_wr_tile,
  output logic [3:0]           o_countdown,
  output logic                 o_armed
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WRITE_BOMB,
    S_COUNT,
    S_READ_NB,
    S_CLEAR_NB,
    S_CLEAR_CTR
  } state_t;

  state_t               state_q;
  logic                 pending_q;
  arena_pkg::tile_pos_t bomb_pos_q;
  logic [1:0]           nb_idx_q;
  logic [3:0]           count_q;
  logic                 armed_q;
  arena_pkg::tile_pos_t nb_pos;
  logic                 nb_valid;
  logic                 last_nb;

  // Index 0..3 walks up, down, left, right
  assign nb_pos   = arena_pkg::step_pos(bomb_pos_q, arena_pkg::dir_t'({1'b0, nb_idx_q} + 3'd1));
  assign nb_valid = arena_pkg::in_map(nb_pos);
  assign last_nb  = (nb_idx_q == 2'd3);

  always_ff @(posedge i_pixclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q    <= S_IDLE;
      pending_q  <= 1'b0;
      bomb_pos_q <= '0;
      nb_idx_q   <= '0;
      count_q    <= '0;
      armed_q    <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          // Place requests only count with no bomb out
          if (i_place) begin
            pending_q <= 1'b1;
          end
          if (i_tick && pending_q) begin
            pending_q  <= 1'b0;
            bomb_pos_q <= i_pos;
            state_q    <= S_WRITE_BOMB;
          end
        end
        S_WRITE_BOMB: begin
          count_q <= 4'(`BOMB_FRAMES);
          armed_q <= 1'b1;
          state_q <= S_COUNT;
        end
        S_COUNT: begin
          if (i_tick) begin
            if (count_q == 4'd1) begin
              nb_idx_q <= '0;
              state_q  <= S_READ_NB;
            end else begin
              count_q <= count_q - 4'd1;
            end
          end
        end
        S_READ_NB: begin
          // Off-map neighbours are skipped without a read
          if (!nb_valid || (rd.gnt && rd.tile != arena_pkg::TILE_BRICK)) begin
            if (last_nb) begin
              state_q <= S_CLEAR_CTR;
            end else begin
              nb_idx_q <= nb_idx_q + 2'd1;
            end
          end else if (rd.gnt) begin
            state_q <= S_CLEAR_NB;
          end
        end
        S_CLEAR_NB: begin
          if (last_nb) begin
            state_q <= S_CLEAR_CTR;
          end else begin
            nb_idx_q <= nb_idx_q + 2'd1;
            state_q  <= S_READ_NB;
          end
        end
        S_CLEAR_CTR: begin
          count_q <= '0;
          armed_q <= 1'b0;
          state_q <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Neighbour reads
  assign rd.req  = (state_q == S_READ_NB) && nb_valid;
  assign rd.addr = arena_pkg::pos_to_addr(nb_pos);

  // Map writes, bomb in or floor back
  assign o_we      = (state_q == S_WRITE_BOMB) || (state_q == S_CLEAR_NB) ||
                     (state_q == S_CLEAR_CTR);
  assign o_wr_addr = (state_q == S_CLEAR_NB) ? arena_pkg::pos_to_addr(nb_pos)
                                             : arena_pkg::pos_to_addr(bomb_pos_q);
  assign o_wr_tile = (state_q == S_WRITE_BOMB) ? arena_pkg::TILE_BOMB : arena_pkg::TILE_FLOOR;

  assign o_countdown = count_q;
  assign o_armed     = armed_q;

endmodule

// File: logic/video_timing.sv
`timescale 1ns/1ps

`include "arena_params.svh"

module video_timing (
  input  logic              i_pixclk,
  input  logic              i_arst_n,
  output video_pkg::scr_x_t o_x,
  output video_pkg::scr_y_t o_y,
  output logic              o_active,
  output logic              o_tick,
  output logic              o_hsync,
  output logic              o_vsync
);

  localparam int HS_START = `H_ACTIVE + `H_FRONT;
  localparam int HS_END   = HS_START + `H_SYNC;
  localparam int VS_START = `V_ACTIVE + `V_FRONT;
  localparam int VS_END   = VS_START + `V_SYNC;

  video_pkg::scr_x_t       h_cnt;
  video_pkg::scr_y_t       v_cnt;
  logic                    hs_raw;
  logic                    vs_raw;
  logic                    act_raw;
  logic [`PIPE_DELAY-1:0]  hs_d;
  logic [`PIPE_DELAY-1:0]  vs_d;
  logic [`PIPE_DELAY-1:0]  act_d;

  // Column and line counters
  always_ff @(posedge i_pixclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (int'(h_cnt) == `H_TOTAL - 1) begin
      h_cnt <= '0;
      v_cnt <= (int'(v_cnt) == `V_TOTAL - 1) ? '0 : v_cnt + 7'd1;
    end else begin
      h_cnt <= h_cnt + 8'd1;
    end
  end

  // Syncs are active low
  assign hs_raw  = !(int'(h_cnt) >= HS_START && int'(h_cnt) < HS_END);
  assign vs_raw  = !(int'(v_cnt) >= VS_START && int'(v_cnt) < VS_END);
  assign act_raw = (int'(h_cnt) < `H_ACTIVE) && (int'(v_cnt) < `V_ACTIVE);

  // Match the renderer latency
  always_ff @(posedge i_pixclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      hs_d  <= '1;
      vs_d  <= '1;
      act_d <= '0;
    end else begin
      hs_d  <= {hs_d[`PIPE_DELAY-2:0], hs_raw};
      vs_d  <= {vs_d[`PIPE_DELAY-2:0], vs_raw};
      act_d <= {act_d[`PIPE_DELAY-2:0], act_raw};
    end
  end

  assign o_x      = h_cnt;
  assign o_y      = v_cnt;
  // Frame start pulse
  assign o_tick   = (h_cnt == '0) && (v_cnt == '0);
  assign o_hsync  = hs_d[`PIPE_DELAY-1];
  assign o_vsync  = vs_d[`PIPE_DELAY-1];
  assign o_active = act_d[`PIPE_DELAY-1];

endmodule

// File: logic/tile_renderer.sv
`timescale 1ns/1ps

`include "arena_params.svh"

module tile_renderer (
  input  logic                 i_pixclk,
  input  logic                 i_arst_n,
  input  video_pkg::scr_x_t    i_x,
  input  video_pkg::scr_y_t    i_y,
  input  logic                 i_active,
  input  arena_pkg::tile_t     i_draw_tile,
  input  arena_pkg::tile_pos_t i_player,
  output arena_pkg::map_addr_t o_draw_addr,
  output video_pkg::rgb_t      o_rgb
);

  arena_pkg::tile_pos_t beam_pos;
  logic                 on_player_q;
  video_pkg::rgb_t      tile_rgb;
  video_pkg::rgb_t      colour_q;

  // Stage one, beam to tile
  assign beam_pos.row = 4'(int'(i_y) / `TILE_PX);
  assign beam_pos.col = 5'(int'(i_x) / `TILE_PX);
  assign o_draw_addr  = arena_pkg::pos_to_addr(beam_pos);

  // Tile kind to palette
  always_comb begin
    case (i_draw_tile)
      arena_pkg::TILE_WALL:  tile_rgb = video_pkg::RGB_WALL;
      arena_pkg::TILE_BRICK: tile_rgb = video_pkg::RGB_BRICK;
      arena_pkg::TILE_BOMB:  tile_rgb = video_pkg::RGB_BOMB;
      default:               tile_rgb = video_pkg::RGB_FLOOR;
    endcase
  end

  always_ff @(posedge i_pixclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      on_player_q <= 1'b0;
      colour_q    <= video_pkg::RGB_BLANK;
    end else begin
      on_player_q <= (beam_pos == i_player);
      // Stage two, player drawn over the tile
      colour_q    <= on_player_q ? video_pkg::RGB_PLAYER : tile_rgb;
    end
  end

  // Active arrives already delayed to this stage
  assign o_rgb = i_active ? colour_q : video_pkg::RGB_BLANK;

endmodule

// File: logic/arena_top.sv
`timescale 1ns/1ps

module arena_top (
  input  logic       i_pixclk,
  input  logic       i_arst_n,
  input  logic       i_up,
  input  logic       i_down,
  input  logic       i_left,
  input  logic       i_right,
  input  logic       i_place_bomb,
  output logic [3:0] o_pix_r,
  output logic [3:0] o_pix_g,
  output logic [3:0] o_pix_b,
  output logic       o_hsync,
  output logic       o_vsync,
  output logic [3:0] o_countdown,
  output logic       o_bomb_armed
);

  video_pkg::scr_x_t    beam_x;
  video_pkg::scr_y_t    beam_y;
  logic                 active;
  logic                 tick;
  arena_pkg::dir_t      move_dir;
  arena_pkg::tile_pos_t player_pos;
  arena_pkg::map_addr_t rd_addr;
  arena_pkg::tile_t     rd_tile;
  arena_pkg::map_addr_t draw_addr;
  arena_pkg::tile_t     draw_tile;
  logic                 we;
  arena_pkg::map_addr_t wr_addr;
  arena_pkg::tile_t     wr_tile;
  video_pkg::rgb_t      rgb;

  map_read_if bomb_rd_if ();
  map_read_if plyr_rd_if ();

  // Exactly one button gives a direction
  always_comb begin
    case ({i_up, i_down, i_left, i_right})
      4'b1000: move_dir = arena_pkg::DIR_UP;
      4'b0100: move_dir = arena_pkg::DIR_DOWN;
      4'b0010: move_dir = arena_pkg::DIR_LEFT;
      4'b0001: move_dir = arena_pkg::DIR_RIGHT;
      default: move_dir = arena_pkg::DIR_NONE;
    endcase
  end

  video_timing timing_i (
    .i_pixclk (i_pixclk),
    .i_arst_n (i_arst_n),
    .o_x      (beam_x),
    .o_y      (beam_y),
    .o_active (active),
    .o_tick   (tick),
    .o_hsync  (o_hsync),
    .o_vsync  (o_vsync)
  );

  tile_map map_i (
    .i_pixclk    (i_pixclk),
    .i_arst_n    (i_arst_n),
    .i_rd_addr   (rd_addr),
    .i_draw_addr (draw_addr),
    .i_we        (we),
    .i_wr_addr   (wr_addr),
    .i_wr_tile   (wr_tile),
    .o_rd_tile   (rd_tile),
    .o_draw_tile (draw_tile)
  );

  map_read_arbiter arb_i (
    .i_pixclk  (i_pixclk),
    .i_arst_n  (i_arst_n),
    .bomb_rd   (bomb_rd_if.arbiter),
    .plyr_rd   (plyr_rd_if.arbiter),
    .o_rd_addr (rd_addr),
    .i_rd_tile (rd_tile)
  );

  player_ctrl player_i (
    .i_pixclk (i_pixclk),
    .i_arst_n (i_arst_n),
    .i_tick   (tick),
    .i_dir    (move_dir),
    .rd       (plyr_rd_if.requester),
    .o_pos    (player_pos)
  );

  bomb_ctrl bomb_i (
    .i_pixclk    (i_pixclk),
    .i_arst_n    (i_arst_n),
    .i_tick      (tick),
    .i_place     (i_place_bomb),
    .i_pos       (player_pos),
    .rd          (bomb_rd_if.requester),
    .o_we        (we),
    .o_wr_addr   (wr_addr),
    .o_wr_tile   (wr_tile),
    .o_countdown (o_countdown),
    .o_armed     (o_bomb_armed)
  );

  tile_renderer render_i (
    .i_pixclk    (i_pixclk),
    .i_arst_n    (i_arst_n),
    .i_x         (beam_x),
    .i_y         (beam_y),
    .i_active    (active),
    .i_draw_tile (draw_tile),
    .i_player    (player_pos),
    .o_draw_addr (draw_addr),
    .o_rgb       (rgb)
  );

  // Split colour onto the pins
  assign o_pix_r = rgb.r;
  assign o_pix_g = rgb.g;
  assign o_pix_b = rgb.b;

endmodule

// File: test/arena_tb.sv
`timescale 1ns/1ps

`include "arena_params.svh"

module arena_tb;

  localparam int MAX_ROWS   = 16;
  localparam int MAX_PROBES = 4;
  localparam int HS_START   = `H_ACTIVE + `H_FRONT;
  localparam int VS_START   = `V_ACTIVE + `V_FRONT;
  localparam int FRAME_CYC  = `H_TOTAL * `V_TOTAL;

  // Button bits in the order up down left right place
  localparam logic [4:0] BTN_NONE  = 5'b00000;
  localparam logic [4:0] BTN_UP    = 5'b10000;
  localparam logic [4:0] BTN_DOWN  = 5'b01000;
  localparam logic [4:0] BTN_LEFT  = 5'b00100;
  localparam logic [4:0] BTN_RIGHT = 5'b00010;
  localparam logic [4:0] BTN_PLACE = 5'b00001;

  logic       pixclk;
  logic       arst_n;
  logic       up;
  logic       down;
  logic       left;
  logic       right;
  logic       place_bomb;
  logic [3:0] pix_r;
  logic [3:0] pix_g;
  logic [3:0] pix_b;
  logic       hsync;
  logic       vsync;
  logic [3:0] countdown;
  logic       bomb_armed;

  // Stimulus table
  logic [4:0]           row_btn    [0:MAX_ROWS-1];
  int                   row_frames [0:MAX_ROWS-1];
  arena_pkg::tile_pos_t row_pos    [0:MAX_ROWS-1];
  logic [3:0]           row_count  [0:MAX_ROWS-1];
  logic                 row_armed  [0:MAX_ROWS-1];
  int                   row_nprobe [0:MAX_ROWS-1];
  arena_pkg::tile_pos_t probe_pos  [0:MAX_ROWS-1][0:MAX_PROBES-1];
  arena_pkg::tile_t     probe_exp  [0:MAX_ROWS-1][0:MAX_PROBES-1];
  int                   n_rows = 0;

  // Sampler state
  int              bx;
  int              by;
  int              cyc;
  int              last_hs;
  int              last_vs;
  int              h_period = 0;
  int              v_period = 0;
  int              vs_falls = 0;
  logic            locked;
  logic            prev_hs;
  logic            prev_vs;
  logic            prev_armed;
  logic [3:0]      prev_count;
  logic            snap_en;
  video_pkg::rgb_t snap [0:`ARENA_ROWS-1][0:`ARENA_COLS-1];

  int err_value = 0;
  int err_other = 0;

  arena_top dut_i (
    .i_pixclk     (pixclk),
    .i_arst_n     (arst_n),
    .i_up         (up),
    .i_down       (down),
    .i_left       (left),
    .i_right      (right),
    .i_place_bomb (place_bomb),
    .o_pix_r      (pix_r),
    .o_pix_g      (pix_g),
    .o_pix_b      (pix_b),
    .o_hsync      (hsync),
    .o_vsync      (vsync),
    .o_countdown  (countdown),
    .o_bomb_armed (bomb_armed)
  );

  initial begin
    pixclk = 1'b0;
    forever #50 pixclk = ~pixclk;
  end

  // Start layout with walls on the border and the even pillars
  function automatic arena_pkg::tile_t layout_tile(int r, int c);
    if (r == 0 || c == 0 || r == `ARENA_ROWS - 1 || c == `ARENA_COLS - 1) begin
      return arena_pkg::TILE_WALL;
    end
    if (r % 2 == 0 && c % 2 == 0) begin
      return arena_pkg::TILE_WALL;
    end
    if ((r + c) % 3 == 0 && r + c > 3) begin
      return arena_pkg::TILE_BRICK;
    end
    return arena_pkg::TILE_FLOOR;
  endfunction

  function automatic video_pkg::rgb_t tile_colour(arena_pkg::tile_t t);
    case (t)
      arena_pkg::TILE_WALL:  return video_pkg::RGB_WALL;
      arena_pkg::TILE_BRICK: return video_pkg::RGB_BRICK;
      arena_pkg::TILE_BOMB:  return video_pkg::RGB_BOMB;
      default:               return video_pkg::RGB_FLOOR;
    endcase
  endfunction

  // Tile code seen on screen or -1 for an unknown colour
  function automatic int colour_code(video_pkg::rgb_t c);
    if (c === video_pkg::RGB_WALL)  return int'(arena_pkg::TILE_WALL);
    if (c === video_pkg::RGB_BRICK) return int'(arena_pkg::TILE_BRICK);
    if (c === video_pkg::RGB_BOMB)  return int'(arena_pkg::TILE_BOMB);
    if (c === video_pkg::RGB_FLOOR) return int'(arena_pkg::TILE_FLOOR);
    return -1;
  endfunction

  task automatic check_tile(arena_pkg::tile_t got, arena_pkg::tile_t exp, string what);
    if (got !== exp) begin
      err_value++;
      $display("[ERROR] %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
    end
  endtask

  task automatic check_rgb(video_pkg::rgb_t got, video_pkg::rgb_t exp, string what);
    if (got !== exp) begin
      err_value++;
      $display("[ERROR] %0t: %s colour is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(logic [3:0] got, logic [3:0] exp, string what);
    if (got !== exp) begin
      err_value++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_level(logic got, logic exp, string what);
    if (got !== exp) begin
      err_value++;
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_period(int got, int exp, string what);
    if (got != exp) begin
      err_value++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Summary: %0d value errors, %0d other errors", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  endtask

  task automatic add_row(logic [4:0] btn, int frames, int prow, int pcol,
                         logic [3:0] cnt, logic armed);
    row_btn[n_rows]     = btn;
    row_frames[n_rows]  = frames;
    row_pos[n_rows].row = 4'(prow);
    row_pos[n_rows].col = 5'(pcol);
    row_count[n_rows]   = cnt;
    row_armed[n_rows]   = armed;
    row_nprobe[n_rows]  = 0;
    n_rows++;
  endtask

  // Probe goes on the row added last
  task automatic add_probe(int prow, int pcol, arena_pkg::tile_t t);
    int r;
    int k;
    r = n_rows - 1;
    k = row_nprobe[r];
    probe_pos[r][k].row = 4'(prow);
    probe_pos[r][k].col = 5'(pcol);
    probe_exp[r][k]     = t;
    row_nprobe[r]       = k + 1;
  endtask

  // Every row also spends one idle frame on capture and sees one more tick
  task automatic load_table();
    add_row(BTN_NONE, 1, 1, 1, 4'd0, 1'b0);
    add_probe(0, 0, arena_pkg::TILE_WALL);
    add_probe(2, 2, arena_pkg::TILE_WALL);
    add_probe(1, 5, arena_pkg::TILE_BRICK);
    add_probe(1, 2, arena_pkg::TILE_FLOOR);
    // Blocked by the border
    add_row(BTN_UP, 1, 1, 1, 4'd0, 1'b0);
    add_probe(0, 1, arena_pkg::TILE_WALL);
    add_probe(1, 2, arena_pkg::TILE_FLOOR);
    add_row(BTN_LEFT, 1, 1, 1, 4'd0, 1'b0);
    add_probe(1, 0, arena_pkg::TILE_WALL);
    // Two buttons give no direction
    add_row(BTN_RIGHT | BTN_DOWN, 1, 1, 1, 4'd0, 1'b0);
    add_probe(1, 2, arena_pkg::TILE_FLOOR);
    add_probe(2, 1, arena_pkg::TILE_FLOOR);
    // Three steps then the brick at (1,5)
    add_row(BTN_RIGHT, 4, 1, 4, 4'd0, 1'b0);
    add_probe(1, 5, arena_pkg::TILE_BRICK);
    add_probe(1, 3, arena_pkg::TILE_FLOOR);
    add_probe(1, 1, arena_pkg::TILE_FLOOR);
    // Placed on the first tick and the capture tick counts one down
    add_row(BTN_PLACE, 1, 1, 4, 4'd8, 1'b1);
    add_probe(1, 3, arena_pkg::TILE_FLOOR);
    add_probe(1, 5, arena_pkg::TILE_BRICK);
    // Second place while armed
    add_row(BTN_LEFT | BTN_PLACE, 1, 1, 3, 4'd6, 1'b1);
    add_probe(1, 4, arena_pkg::TILE_BOMB);
    add_probe(1, 5, arena_pkg::TILE_BRICK);
    add_row(BTN_LEFT, 2, 1, 1, 4'd3, 1'b1);
    add_probe(1, 4, arena_pkg::TILE_BOMB);
    add_probe(1, 3, arena_pkg::TILE_FLOOR);
    add_probe(1, 2, arena_pkg::TILE_FLOOR);
    add_row(BTN_NONE, 1, 1, 1, 4'd1, 1'b1);
    add_probe(1, 4, arena_pkg::TILE_BOMB);
    add_probe(1, 5, arena_pkg::TILE_BRICK);
    // Blast clears the bomb and the brick on its right
    add_row(BTN_NONE, 1, 1, 1, 4'd0, 1'b0);
    add_probe(1, 4, arena_pkg::TILE_FLOOR);
    add_probe(1, 5, arena_pkg::TILE_FLOOR);
    add_probe(0, 4, arena_pkg::TILE_WALL);
    add_probe(2, 4, arena_pkg::TILE_WALL);
    // Walk through the cleared brick
    add_row(BTN_RIGHT, 5, 1, 6, 4'd0, 1'b0);
    add_probe(1, 5, arena_pkg::TILE_FLOOR);
    add_probe(1, 4, arena_pkg::TILE_FLOOR);
    add_probe(1, 8, arena_pkg::TILE_BRICK);
    add_probe(0, 5, arena_pkg::TILE_WALL);
  endtask

  // Beam position at the ports rebuilt from the sync edges
  always @(negedge pixclk) begin
    if (!arst_n) begin
      locked     = 1'b0;
      prev_hs    = 1'b1;
      prev_vs    = 1'b1;
      prev_armed = 1'b0;
      prev_count = 4'd0;
      bx         = 0;
      by         = 0;
      cyc        = 0;
      last_hs    = 0;
      last_vs    = 0;
    end else begin
      cyc = cyc + 1;
      if (bx == `H_TOTAL - 1) begin
        bx = 0;
        by = (by + 1) % `V_TOTAL;
      end else begin
        bx = bx + 1;
      end
      if (prev_hs && !hsync) begin
        if (last_hs > 0) begin
          h_period = cyc - last_hs;
        end
        last_hs = cyc;
        bx      = HS_START;
      end
      // Vsync falls at the first pixel of its line
      if (prev_vs && !vsync) begin
        if (last_vs > 0) begin
          v_period = cyc - last_vs;
        end
        last_vs  = cyc;
        bx       = 0;
        by       = VS_START;
        locked   = 1'b1;
        vs_falls = vs_falls + 1;
      end
      // Centre pixel of each tile
      if (snap_en && locked && bx < `H_ACTIVE && by < `V_ACTIVE &&
          bx % `TILE_PX == `TILE_PX / 2 && by % `TILE_PX == `TILE_PX / 2) begin
        snap[by / `TILE_PX][bx / `TILE_PX] = {pix_r, pix_g, pix_b};
      end
      // Colour and syncs agree on where the active area ends
      if (snap_en && locked && by < `V_ACTIVE) begin
        if (bx == `H_ACTIVE - 1) begin
          check_rgb({pix_r, pix_g, pix_b}, video_pkg::RGB_WALL, "last active pixel");
        end else if (bx == `H_ACTIVE) begin
          check_rgb({pix_r, pix_g, pix_b}, video_pkg::RGB_BLANK, "first blank pixel");
        end
      end
      // Countdown starts full and steps down by one
      if (bomb_armed && !prev_armed) begin
        check_count(countdown, 4'(`BOMB_FRAMES), "countdown at arming");
      end else if (bomb_armed && prev_armed && countdown != prev_count) begin
        check_count(countdown, 4'(prev_count - 4'd1), "countdown step");
      end
      prev_hs    = hsync;
      prev_vs    = vsync;
      prev_armed = bomb_armed;
      prev_count = countdown;
    end
  end

  task automatic wait_vsync_fall();
    int start;
    int waited;
    start  = vs_falls;
    waited = 0;
    while (vs_falls == start && waited < 2 * FRAME_CYC) begin
      @(posedge pixclk);
      waited++;
    end
    if (vs_falls == start) begin
      err_other++;
      $display("Timeout at %0t: no vsync falling edge within %0d cycles", $time, waited);
      finish_run();
    end
  endtask

  // One full frame of tile centres
  task automatic capture_frame();
    for (int r = 0; r < `ARENA_ROWS; r++) begin
      for (int c = 0; c < `ARENA_COLS; c++) begin
        snap[r][c] = 'x;
      end
    end
    snap_en = 1'b1;
    wait_vsync_fall();
    snap_en = 1'b0;
  endtask

  task automatic probe_tile(int r, int c, arena_pkg::tile_t exp);
    video_pkg::rgb_t got;
    int              code;
    string           what;
    got  = snap[r][c];
    code = colour_code(got);
    what = $sformatf("tile (%0d,%0d)", r, c);
    if (code < 0) begin
      check_rgb(got, tile_colour(exp), what);
    end else begin
      check_tile(arena_pkg::tile_t'(code), exp, what);
    end
  endtask

  // Whole map against the start layout except the player tile
  task automatic check_layout();
    for (int r = 0; r < `ARENA_ROWS; r++) begin
      for (int c = 0; c < `ARENA_COLS; c++) begin
        if (!(r == `START_ROW && c == `START_COL)) begin
          probe_tile(r, c, layout_tile(r, c));
        end
      end
    end
  endtask

  task automatic apply_row(int idx);
    arena_pkg::tile_pos_t p;
    @(posedge pixclk);
    up         <= row_btn[idx][4];
    down       <= row_btn[idx][3];
    left       <= row_btn[idx][2];
    right      <= row_btn[idx][1];
    place_bomb <= row_btn[idx][0];
    for (int f = 0; f < row_frames[idx]; f++) begin
      wait_vsync_fall();
    end
    @(posedge pixclk);
    up         <= 1'b0;
    down       <= 1'b0;
    left       <= 1'b0;
    right      <= 1'b0;
    place_bomb <= 1'b0;
    capture_frame();
    check_count(countdown, row_count[idx], $sformatf("row %0d countdown", idx));
    check_level(bomb_armed, row_armed[idx], $sformatf("row %0d armed", idx));
    p = row_pos[idx];
    check_rgb(snap[p.row][p.col], video_pkg::RGB_PLAYER,
              $sformatf("row %0d player at (%0d,%0d)", idx, p.row, p.col));
    for (int k = 0; k < row_nprobe[idx]; k++) begin
      probe_tile(probe_pos[idx][k].row, probe_pos[idx][k].col, probe_exp[idx][k]);
    end
    if (idx == 0) begin
      check_layout();
      check_period(h_period, `H_TOTAL, "hsync period in cycles");
      check_period(v_period, FRAME_CYC, "vsync period in cycles");
    end
  endtask

  initial begin
    arst_n     = 1'b0;
    up         = 1'b0;
    down       = 1'b0;
    left       = 1'b0;
    right      = 1'b0;
    place_bomb = 1'b0;
    snap_en    = 1'b0;
    load_table();
    repeat (10) @(posedge pixclk);
    arst_n <= 1'b1;
    @(posedge pixclk);
    check_count(countdown, 4'd0, "countdown after reset");
    check_level(bomb_armed, 1'b0, "armed after reset");
    // Rows chain from one vsync edge to the next
    wait_vsync_fall();
    for (int i = 0; i < n_rows; i++) begin
      apply_row(i);
    end
    finish_run();
  end

endmodule

// File: sources.f
+incdir+logic
logic/arena_pkg.sv
logic/video_pkg.sv
logic/map_read_if.sv
logic/tile_map.sv
logic/map_read_arbiter.sv
logic/player_ctrl.sv
logic/bomb_ctrl.sv
logic/video_timing.sv
logic/tile_renderer.sv
logic/arena_top.sv
test/arena_tb.sv
